// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cacheTb
LOG ?= sim.log
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== src/cachePkg.sv ====
package cachePkg;

	// geometry
	localparam int wordBits = 32;
	localparam int wordsPerLine = 16;
	localparam int numSets = 512;
	localparam int numWays = 2;

	// address split
	localparam int offsetBits = 6;
	localparam int indexBits = 9;
	localparam int tagBits = 49;

	// byte address, tag | index | offset
	typedef logic [tagBits+indexBits+offsetBits-1:0] addr_t;

	typedef logic [tagBits-1:0] tag_t;
	typedef logic [indexBits-1:0] index_t;

	// word within a line, addr bits 5:2
	typedef logic [$clog2(wordsPerLine)-1:0] wordSel_t;

	typedef logic [wordBits-1:0] word_t;

	// word 0 sits in the low bits
	typedef logic [wordsPerLine*wordBits-1:0] line_t;

	typedef logic [$clog2(numWays)-1:0] way_t;

	typedef enum logic {
		opRead,
		opWrite
	} cacheOp_t;

	typedef enum logic [2:0] {
		stIdle,
		stLookup,
		stWriteBack,
		stFill,
		stDone
	} ctrlState_t;

endpackage

// ==== src/cacheTop.sv ====
`timescale 1ns/10ps

module cacheTop import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input cacheOp_t op,
	input addr_t addr,
	input word_t writeData,
	output word_t readData,
	output logic done,
	output logic busy,
	output logic storeEnable,
	output addr_t storeAddr,
	output line_t flushData,
	input logic storeReady,
	output logic fillEnable,
	output addr_t fillAddr,
	input line_t fillData,
	input logic fillReady
);

	// tag side
	index_t lookupIndex;
	tag_t lookupTag;
	logic tagWrite;
	way_t fillWay;
	way_t touchWay;
	logic setDirty;
	logic hit;
	way_t hitWay;
	way_t victimWay;
	logic victimDirty;
	tag_t victimTag;

	// data side
	index_t dataIndex;
	way_t dataWay;
	wordSel_t wordSel;
	logic wordWrite;
	word_t wordIn;
	logic lineWrite;
	line_t lineIn;
	word_t wordOut;
	line_t lineOut;

	tagStore tagStore_i (
		.clk(clk), .reset(reset),
		.lookupIndex(lookupIndex), .lookupTag(lookupTag),
		.tagWrite(tagWrite), .fillWay(fillWay), .touchWay(touchWay), .setDirty(setDirty),
		.hit(hit), .hitWay(hitWay),
		.victimWay(victimWay), .victimDirty(victimDirty), .victimTag(victimTag)
	);

	dataStore dataStore_i (
		.clk(clk),
		.dataIndex(dataIndex), .dataWay(dataWay), .wordSel(wordSel),
		.wordWrite(wordWrite), .wordIn(wordIn),
		.lineWrite(lineWrite), .lineIn(lineIn),
		.wordOut(wordOut), .lineOut(lineOut)
	);

	missController missController_i (
		.clk(clk), .reset(reset),
		.req(req), .op(op), .addr(addr), .writeData(writeData),
		.hit(hit), .hitWay(hitWay),
		.victimWay(victimWay), .victimDirty(victimDirty), .victimTag(victimTag),
		.wordOut(wordOut), .lineOut(lineOut),
		.storeReady(storeReady), .fillReady(fillReady), .fillData(fillData),
		.busy(busy), .done(done), .readData(readData),
		.storeEnable(storeEnable), .storeAddr(storeAddr), .flushData(flushData),
		.fillEnable(fillEnable), .fillAddr(fillAddr),
		.lookupIndex(lookupIndex), .lookupTag(lookupTag),
		.tagWrite(tagWrite), .fillWay(fillWay), .touchWay(touchWay), .setDirty(setDirty),
		.dataIndex(dataIndex), .dataWay(dataWay), .wordSel(wordSel),
		.wordWrite(wordWrite), .wordIn(wordIn),
		.lineWrite(lineWrite), .lineIn(lineIn)
	);

endmodule

// ==== src/dataStore.sv ====
`timescale 1ns/10ps

module dataStore import cachePkg::*; (
	input logic clk,
	input index_t dataIndex,
	input way_t dataWay,
	input wordSel_t wordSel,
	input logic wordWrite,
	input word_t wordIn,
	input logic lineWrite,
	input line_t lineIn,
	output word_t wordOut,
	output line_t lineOut
);

	line_t lines [numWays][numSets];

	line_t rowRead;

	assign rowRead = lines[dataWay][dataIndex];

	// a fill replaces the whole line, otherwise a single word
	always_ff @(posedge clk) begin
		if (lineWrite) begin
			lines[dataWay][dataIndex] <= lineIn;
		end else if (wordWrite) begin
			lines[dataWay][dataIndex][wordSel*wordBits +: wordBits] <= wordIn;
		end
	end

	// registered reads, old data on a same-cycle write
	always_ff @(posedge clk) begin
		lineOut <= rowRead;
		wordOut <= rowRead[wordSel*wordBits +: wordBits];
	end

endmodule

// ==== src/missController.sv ====
`timescale 1ns/10ps

module missController import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input cacheOp_t op,
	input addr_t addr,
	input word_t writeData,
	input logic hit,
	input way_t hitWay,
	input way_t victimWay,
	input logic victimDirty,
	input tag_t victimTag,
	input word_t wordOut,
	input line_t lineOut,
	input logic storeReady,
	input logic fillReady,
	input line_t fillData,
	output logic busy,
	output logic done,
	output word_t readData,
	output logic storeEnable,
	output addr_t storeAddr,
	output line_t flushData,
	output logic fillEnable,
	output addr_t fillAddr,
	output index_t lookupIndex,
	output tag_t lookupTag,
	output logic tagWrite,
	output way_t fillWay,
	output way_t touchWay,
	output logic setDirty,
	output index_t dataIndex,
	output way_t dataWay,
	output wordSel_t wordSel,
	output logic wordWrite,
	output word_t wordIn,
	output logic lineWrite,
	output line_t lineIn
);

	ctrlState_t state;

	addr_t reqAddr;
	cacheOp_t reqOp;
	word_t reqData;
	way_t victimReg;
	tag_t victimTagReg;
	logic reqSent; // enable already pulsed in this state
	logic inMiss;

	assign lookupIndex = reqAddr[offsetBits +: indexBits];
	assign lookupTag = reqAddr[offsetBits+indexBits +: tagBits];
	assign wordSel = reqAddr[$clog2(wordBits/8) +: $bits(wordSel_t)];
	assign dataIndex = lookupIndex;

	assign inMiss = (state == stWriteBack) || (state == stFill);
	assign dataWay = inMiss ? victimReg : (hit ? hitWay : victimWay);
	assign touchWay = dataWay;

	assign wordWrite = (state == stLookup) && hit && (reqOp == opWrite);
	assign setDirty = wordWrite;
	assign wordIn = reqData;

	assign lineWrite = (state == stFill) && reqSent && fillReady;
	assign tagWrite = lineWrite; // tag and data installed together
	assign lineIn = fillData;
	assign fillWay = victimReg;

	assign storeAddr = {victimTagReg, lookupIndex, {offsetBits{1'b0}}};
	assign fillAddr = {reqAddr[$bits(addr_t)-1:offsetBits], {offsetBits{1'b0}}};

	always_ff @(posedge clk) begin
		if (req && !busy) begin
			reqAddr <= addr;
			reqOp <= op;
			reqData <= writeData;
		end
		if (state == stLookup && !hit) begin
			victimReg <= victimWay;
			victimTagReg <= victimTag;
		end
		if (state == stWriteBack && !reqSent) begin
			flushData <= lineOut; // victim line read during lookup
		end
		if (state == stDone) begin
			readData <= wordOut;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			busy <= 1'b0;
			done <= 1'b0;
			storeEnable <= 1'b0;
			fillEnable <= 1'b0;
			reqSent <= 1'b0;
		end else begin
			done <= 1'b0;
			storeEnable <= 1'b0;
			fillEnable <= 1'b0;
			if (done) begin
				busy <= 1'b0; // held through the done cycle
			end
			case (state)
				stIdle: begin
					if (req && !busy) begin
						state <= stLookup;
						busy <= 1'b1;
					end
				end
				stLookup: begin
					reqSent <= 1'b0;
					if (hit) begin
						state <= stDone;
					end else if (victimDirty) begin
						state <= stWriteBack;
					end else begin
						state <= stFill;
					end
				end
				stWriteBack: begin
					if (!reqSent) begin
						storeEnable <= 1'b1;
						reqSent <= 1'b1;
					end else if (storeReady) begin
						reqSent <= 1'b0;
						state <= stFill;
					end
				end
				stFill: begin
					if (!reqSent) begin
						fillEnable <= 1'b1;
						reqSent <= 1'b1;
					end else if (fillReady) begin
						state <= stLookup; // replay, now a hit
					end
				end
				stDone: begin
					done <= 1'b1;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== src/tagStore.sv ====
`timescale 1ns/10ps

module tagStore import cachePkg::*; (
	input logic clk,
	input logic reset,
	input index_t lookupIndex,
	input tag_t lookupTag,
	input logic tagWrite,
	input way_t fillWay,
	input way_t touchWay,
	input logic setDirty,
	output logic hit,
	output way_t hitWay,
	output way_t victimWay,
	output logic victimDirty,
	output tag_t victimTag
);

	tag_t tags [numWays][numSets];
	logic [numSets-1:0] valid [numWays];
	logic [numSets-1:0] dirty [numWays];
	logic [numSets-1:0] lru; // holds the least recently used way of each set

	logic [numWays-1:0] wayHit;

	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			wayHit[w] = valid[w][lookupIndex] && (tags[w][lookupIndex] == lookupTag);
		end
	end

	assign hit = |wayHit;
	assign hitWay = way_t'(wayHit[1]); // two ways only, way 1 or else way 0

	// victim is always the LRU way
	assign victimWay = lru[lookupIndex];
	assign victimDirty = dirty[victimWay][lookupIndex];
	assign victimTag = tags[victimWay][lookupIndex];

	always_ff @(posedge clk) begin
		if (tagWrite) begin
			tags[fillWay][lookupIndex] <= lookupTag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '{default: '0};
			dirty <= '{default: '0};
			lru <= '0;
		end else begin
			if (tagWrite) begin
				valid[fillWay][lookupIndex] <= 1'b1;
				dirty[fillWay][lookupIndex] <= 1'b0; // fresh line is clean
			end
			// a lookup that hits is a touch
			if (hit) begin
				lru[lookupIndex] <= ~touchWay;
				if (setDirty) begin
					dirty[touchWay][lookupIndex] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== testbench/cacheTb.sv ====
`timescale 1ns/10ps

module cacheTb import cachePkg::*; ();

	typedef struct {
		string name;
		cacheOp_t op;
		addr_t addr;
		word_t data;
		word_t expData; // reads only
		int fills;
		addr_t storeLine; // zero when no writeback is due
		int storeSel;
		word_t storeWord;
	} testRow_t;

	// set 5 holds lines X, Y, Z and V, set 9 holds W
	testRow_t tests [16] = '{
		'{"readMissX", opRead, 64'hA50000814C, 32'h0, 32'hC0DE814C, 1, 64'h0, 0, 32'h0},
		'{"readHitX", opRead, 64'hA50000814C, 32'h0, 32'hC0DE814C, 0, 64'h0, 0, 32'h0},
		'{"writeHitX", opWrite, 64'hA50000814C, 32'h12345678, 32'h0, 0, 64'h0, 0, 32'h0},
		'{"readBackX", opRead, 64'hA50000814C, 32'h0, 32'h12345678, 0, 64'h0, 0, 32'h0},
		'{"otherWordX", opRead, 64'hA500008150, 32'h0, 32'hC0DE8150, 0, 64'h0, 0, 32'h0},
		'{"writeMissW", opWrite, 64'hA50000825C, 32'hDEADBEEF, 32'h0, 1, 64'h0, 0, 32'h0},
		'{"readBackW", opRead, 64'hA50000825C, 32'h0, 32'hDEADBEEF, 0, 64'h0, 0, 32'h0},
		'{"readMissY", opRead, 64'hA500010140, 32'h0, 32'hC0DF0140, 1, 64'h0, 0, 32'h0},
		'{"evictX", opRead, 64'hA500018148, 32'h0, 32'hC0DF8148,
			1, 64'hA500008140, 3, 32'h12345678},
		'{"refillX", opRead, 64'hA50000814C, 32'h0, 32'h12345678, 1, 64'h0, 0, 32'h0},
		'{"refillOtherX", opRead, 64'hA500008150, 32'h0, 32'hC0DE8150, 0, 64'h0, 0, 32'h0},
		'{"dirtyX", opWrite, 64'hA500008154, 32'h5555AAAA, 32'h0, 0, 64'h0, 0, 32'h0},
		'{"dirtyZ", opWrite, 64'hA500018144, 32'hCAFE0001, 32'h0, 0, 64'h0, 0, 32'h0},
		'{"touchX", opRead, 64'hA50000814C, 32'h0, 32'h12345678, 0, 64'h0, 0, 32'h0},
		'{"evictZ", opRead, 64'hA500010140, 32'h0, 32'hC0DF0140,
			1, 64'hA500018140, 1, 32'hCAFE0001},
		'{"evictX2", opRead, 64'hA500020140, 32'h0, 32'hC0DC0140,
			1, 64'hA500008140, 5, 32'h5555AAAA}
	};

	logic clk;
	logic reset;
	logic req;
	cacheOp_t op;
	addr_t addr;
	word_t writeData;
	word_t readData;
	logic done;
	logic busy;
	logic storeEnable;
	addr_t storeAddr;
	line_t flushData;
	logic storeReady;
	logic fillEnable;
	addr_t fillAddr;
	line_t fillData;
	logic fillReady;

	int valueErrors;
	int otherErrors;
	logic timedOut;

	always #4 clk = ~clk;

	cacheTop cacheTop_i (.*);
	memoryModel memory (.*);

	task automatic checkWord(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkAddr(string name, addr_t expected, addr_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkLevel(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic runRow(testRow_t row);
		int fillsBefore;
		int storesBefore;
		int stores;
		int cycles;
		line_t flushed;
		fillsBefore = memory.fillCount;
		storesBefore = memory.storeLog.size();
		@(posedge clk);
		req <= 1'b1;
		op <= row.op;
		addr <= row.addr;
		writeData <= row.data;
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		checkLevel({row.name, " busy"}, 1'b1, busy); // raised the cycle after the strobe
		cycles = 0;
		while (!done && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("%s: the cache gave no done within 200 cycles", row.name);
			otherErrors++;
			timedOut = 1'b1;
		end else begin
			if (row.op == opRead) begin
				checkWord(row.name, row.expData, readData);
			end
			if (memory.fillCount - fillsBefore != row.fills) begin
				$display("%s: expected %0d line fills but saw %0d", row.name, row.fills,
					memory.fillCount - fillsBefore);
				otherErrors++;
			end
			stores = memory.storeLog.size() - storesBefore;
			if (stores != ((row.storeLine != 0) ? 1 : 0)) begin
				$display("%s: wrong number of writebacks, saw %0d", row.name, stores);
				otherErrors++;
			end else if (stores == 1) begin
				flushed = memory.lineLog[memory.lineLog.size()-1];
				checkAddr(row.name, row.storeLine, memory.storeLog[memory.storeLog.size()-1]);
				checkWord(row.name, row.storeWord, flushed[row.storeSel*wordBits +: wordBits]);
			end
			@(negedge clk);
			checkLevel({row.name, " busy"}, 1'b0, busy); // falls with done
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		op = opRead;
		addr = '0;
		writeData = '0;
		valueErrors = 0;
		otherErrors = 0;
		timedOut = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < 16 && !timedOut; i++) begin
			runRow(tests[i]);
		end
		repeat (2) @(posedge clk);
		$display("errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
			cacheTop_i.protocolChecks.failures);
		if (valueErrors + otherErrors + cacheTop_i.protocolChecks.failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== testbench/cacheTop_assert.sv ====
`timescale 1ns/10ps

module cacheTop_assert (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic storeEnable,
	input logic fillEnable
);

	int failures = 0;

	donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			failures++;
			$error("done stayed high for more than one cycle");
		end

	storePulse: assert property (@(posedge clk) disable iff (reset) storeEnable |=> !storeEnable)
		else begin
			failures++;
			$error("storeEnable stayed high for more than one cycle");
		end

	fillPulse: assert property (@(posedge clk) disable iff (reset) fillEnable |=> !fillEnable)
		else begin
			failures++;
			$error("fillEnable stayed high for more than one cycle");
		end

	// busy covers the done cycle
	doneBusy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else begin
			failures++;
			$error("done pulsed while busy was low");
		end

	oneRequest: assert property (@(posedge clk) disable iff (reset) !(storeEnable && fillEnable))
		else begin
			failures++;
			$error("storeEnable and fillEnable were high together");
		end

endmodule

bind cacheTop cacheTop_assert protocolChecks (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.storeEnable(storeEnable),
	.fillEnable(fillEnable)
);

// ==== testbench/memoryModel.sv ====
`timescale 1ns/10ps

module memoryModel import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic storeEnable,
	input addr_t storeAddr,
	input line_t flushData,
	output logic storeReady,
	input logic fillEnable,
	input addr_t fillAddr,
	output line_t fillData,
	output logic fillReady
);

	line_t stored [addr_t]; // written back lines by line address
	addr_t storeLog [$];
	line_t lineLog [$];
	int fillCount;
	logic [31:0] lfsrState;
	int storeWait;
	int fillWait;
	addr_t pendingFill;

	initial begin
		storeReady = 1'b0;
		fillReady = 1'b0;
		fillData = '0;
		fillCount = 0;
		lfsrState = 32'h2151;
		storeWait = 0;
		fillWait = 0;
		pendingFill = '0;
	end

	function automatic logic takeBit();
		logic out;
		out = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (out) begin
			lfsrState = lfsrState ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
		end
		return out;
	endfunction

	// 1 to 8 cycles, three bits
	function automatic int replyDelay();
		int d;
		d = 1;
		for (int b = 0; b < 3; b++) begin
			d += int'(takeBit()) << b;
		end
		return d;
	endfunction

	function automatic line_t lineFor(addr_t lineAddr);
		line_t result;
		logic [31:0] byteAddr;
		if (stored.exists(lineAddr)) begin
			return stored[lineAddr];
		end
		for (int k = 0; k < wordsPerLine; k++) begin
			byteAddr = lineAddr[31:0] + 32'(4 * k);
			result[k*wordBits +: wordBits] = byteAddr ^ 32'hC0DE0000;
		end
		return result;
	endfunction

	always @(posedge clk) begin
		storeReady <= 1'b0;
		fillReady <= 1'b0;
		if (reset) begin
			storeWait <= 0;
			fillWait <= 0;
		end else begin
			if (storeEnable) begin
				stored[storeAddr] = flushData;
				storeLog.push_back(storeAddr);
				lineLog.push_back(flushData);
				storeWait <= replyDelay();
			end else if (storeWait == 1) begin
				storeReady <= 1'b1;
				storeWait <= 0;
			end else if (storeWait > 1) begin
				storeWait <= storeWait - 1;
			end
			if (fillEnable) begin
				pendingFill <= fillAddr;
				fillWait <= replyDelay();
				fillCount++;
			end else if (fillWait == 1) begin
				fillData <= lineFor(pendingFill); // data travels with the ready pulse
				fillReady <= 1'b1;
				fillWait <= 0;
			end else if (fillWait > 1) begin
				fillWait <= fillWait - 1;
			end
		end
	end

endmodule

// ==== vlog.f ====
src/cachePkg.sv
src/tagStore.sv
src/dataStore.sv
src/missController.sv
src/cacheTop.sv
testbench/memoryModel.sv
testbench/cacheTop_assert.sv
testbench/cacheTb.sv
